// File: sources.f
verilog/imul_pkg.sv
verilog/imul_msg_queue.sv
verilog/imul_iter_ctrl.sv
verilog/imul_iter_dpath.sv
verilog/imul_unit.sv
tests/imul_unit_checker.sv
tests/imul_unit_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = imul_unit_tb
FILELIST = sources.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the simulation and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o $(TOP)
	./$(BUILD)/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then exit 1; fi
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// File: tests/imul_unit_tb.sv
// imul unit testbench
// table of edge-case products, then LFSR operands with a randomly stalling consumer

module imul_unit_tb
  import imul_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int          NUM_TABLE      = 16;
  localparam int          NUM_RANDOM     = 16;
  localparam int          NUM_TESTS      = NUM_TABLE + NUM_RANDOM;
  // 40 cycles per test, four times over for back-pressure
  localparam int          TIMEOUT_CYCLES = NUM_TESTS * 40 * 4;
  localparam logic [31:0] LFSR_SEED      = 32'h63d3_70fd;

  // one stimulus row with its hand-worked product
  typedef struct packed {
    mul_req_t                       req;
    logic signed [RESULT_WIDTH-1:0] product;
  } table_row_t;

  logic                    clk = 1'b0;
  logic                    reset;
  mul_req_t                req_msg;
  logic                    req_val;
  logic                    req_rdy;
  mul_resp_t               resp_msg;
  logic                    resp_val;
  logic                    resp_rdy;
  logic                    exp_known;
  logic [RESULT_WIDTH-1:0] exp_product;
  int                      resp_count;
  int                      error_count;
  int                      pending_count;
  int                      peak_pending;
  logic [31:0]             lfsr_state;
  int                      cycle_count = 0;

  imul_unit dut_i (
    .clk      (clk),
    .reset    (reset),
    .req_msg  (req_msg),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_msg (resp_msg),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  imul_unit_checker check_i (
    .clk           (clk),
    .reset         (reset),
    .req_msg       (req_msg),
    .req_val       (req_val),
    .req_rdy       (req_rdy),
    .resp_msg      (resp_msg),
    .resp_val      (resp_val),
    .resp_rdy      (resp_rdy),
    .exp_known     (exp_known),
    .exp_product   (exp_product),
    .resp_count    (resp_count),
    .error_count   (error_count),
    .pending_count (pending_count),
    .peak_pending  (peak_pending)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ----------------------------------------
  // stimulus table and random source
  // ----------------------------------------

  // operand a, operand b, signed product
  function automatic table_row_t table_row(input int idx);
    case (idx)
      0:  return {32'sd0, 32'sd0, 64'sd0};
      1:  return {32'sd1, 32'sd1, 64'sd1};
      2:  return {-32'sd1, -32'sd1, 64'sd1};
      3:  return {32'sd1, -32'sd1, -64'sd1};
      4:  return {-32'sd1, 32'sd1, -64'sd1};
      5:  return {32'sh7fff_ffff, 32'sh7fff_ffff, 64'sh3fff_ffff_0000_0001};
      6:  return {32'sh8000_0000, 32'sh8000_0000, 64'sh4000_0000_0000_0000};
      7:  return {32'sh8000_0000, 32'sh7fff_ffff, 64'shc000_0000_8000_0000};
      8:  return {32'sh8000_0000, -32'sd1, 64'sh0000_0000_8000_0000};
      9:  return {32'sh8000_0000, 32'sd1, 64'shffff_ffff_8000_0000};
      10: return {32'sh7fff_ffff, -32'sd1, 64'shffff_ffff_8000_0001};
      11: return {32'sd12345, -32'sd6789, -64'sd83810205};
      12: return {-32'sd1000, -32'sd1000000, 64'sd1000000000};
      13: return {-32'sd7, 32'sd3, -64'sd21};
      // zero times a negative, sign fix must still give zero
      14: return {32'sd0, -32'sd5, 64'sd0};
      15: return {32'sd65536, 32'sd65536, 64'sd4294967296};
      default: return '0;
    endcase
  endfunction

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // one LFSR step per bit
  task automatic draw_bits(input int n, output logic [31:0] bits);
    int i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      bits = {bits[30:0], lfsr_state[0]};
    end
  endtask

  // hold the request until the edge that accepts it
  task automatic send_request(input mul_req_t r, input logic known,
                              input logic [RESULT_WIDTH-1:0] p, input logic random_rdy);
    logic [31:0] bits;
    req_msg     <= r;
    req_val     <= 1'b1;
    exp_known   <= known;
    exp_product <= p;
    do begin
      @(posedge clk);
      if (random_rdy) begin
        draw_bits(1, bits);
        resp_rdy <= bits[0];
      end
    end while (!req_rdy);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------

  initial begin : stimulus
    mul_req_t    r;
    table_row_t  row;
    logic [31:0] bits;
    logic        count_ok;
    reset       = 1'b1;
    req_msg     = '0;
    req_val     = 1'b0;
    resp_rdy    = 1'b1;
    exp_known   = 1'b0;
    exp_product = '0;
    lfsr_state  = LFSR_SEED;
    count_ok    = 1'b1;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    // one idle edge so the reset state is seen before any request
    @(posedge clk);
    // table, back to back with the consumer always ready
    for (int i = 0; i < NUM_TABLE; i++) begin
      row = table_row(i);
      send_request(row.req, 1'b1, row.product, 1'b0);
    end
    // random operands, consumer stalls at random
    for (int i = 0; i < NUM_RANDOM; i++) begin
      draw_bits(32, bits);
      r.a = bits;
      draw_bits(32, bits);
      r.b = bits;
      send_request(r, 1'b0, '0, 1'b1);
    end
    req_val   <= 1'b0;
    exp_known <= 1'b0;
    // drain, still stalling at random
    while (resp_count < NUM_TESTS) begin
      @(posedge clk);
      draw_bits(1, bits);
      resp_rdy <= bits[0];
    end
    // extra cycles catch a duplicated response
    resp_rdy <= 1'b1;
    repeat (40) @(posedge clk);
    if (resp_count != NUM_TESTS || pending_count != 0) begin
      $display("%0d responses for %0d requests, %0d still pending",
               resp_count, NUM_TESTS, pending_count);
      count_ok = 1'b0;
    end
    // back to back requests queue up behind the busy multiplier
    if (peak_pending < QUEUE_DEPTH + 1) begin
      $display("at most %0d requests were in flight, expected at least %0d",
               peak_pending, QUEUE_DEPTH + 1);
      count_ok = 1'b0;
    end
    $display("tests %0d, responses %0d, errors %0d", NUM_TESTS, resp_count, error_count);
    if (error_count == 0 && count_ok) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // hang guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run hung after %0d cycles with %0d of %0d responses",
               cycle_count, resp_count, NUM_TESTS);
      $display("Test failed");
      $finish;
    end
  end

endmodule

// File: tests/imul_unit_checker.sv
// imul unit checker
// watches the DUT ports, keeps the expected signed products in order and compares

module imul_unit_checker
  import imul_pkg::*;
(
  input  logic                    clk,
  input  logic                    reset,

  // request port of the DUT
  input  mul_req_t                req_msg,
  input  logic                    req_val,
  input  logic                    req_rdy,

  // response port of the DUT
  input  mul_resp_t               resp_msg,
  input  logic                    resp_val,
  input  logic                    resp_rdy,

  // product from the stimulus table, when the request came from it
  input  logic                    exp_known,
  input  logic [RESULT_WIDTH-1:0] exp_product,

  output int                      resp_count,
  output int                      error_count,
  output int                      pending_count,
  output int                      peak_pending
);

  timeunit 1ns;
  timeprecision 1ps;

  // accepted requests and their products, oldest first
  mul_req_t                       sent_q [$];
  logic signed [RESULT_WIDTH-1:0] model_q [$];
  int                             n_resp = 0;
  int                             n_err = 0;
  // most requests accepted and not yet answered at once
  int                             max_in_flight = 0;
  // consumer stall seen on the previous edge
  logic                           stalled = 1'b0;
  mul_resp_t                      held_msg;
  logic                           reset_seen = 1'b0;

  // full signed product, both operands sign extended to the result width
  function automatic logic signed [RESULT_WIDTH-1:0] signed_product(input mul_req_t r);
    logic signed [RESULT_WIDTH-1:0] wide_a;
    logic signed [RESULT_WIDTH-1:0] wide_b;
    wide_a = {{(RESULT_WIDTH-OPERAND_WIDTH){r.a[OPERAND_WIDTH-1]}}, r.a};
    wide_b = {{(RESULT_WIDTH-OPERAND_WIDTH){r.b[OPERAND_WIDTH-1]}}, r.b};
    return wide_a * wide_b;
  endfunction

  // ----------------------------------------
  // port monitor
  // ----------------------------------------

  always @(posedge clk) begin : monitor
    logic signed [RESULT_WIDTH-1:0] expected;
    mul_req_t                       sent;
    if (reset) begin
      reset_seen = 1'b1;
      stalled    = 1'b0;
    end else begin
      // first edge out of reset, nothing sent yet
      if (reset_seen) begin
        reset_seen = 1'b0;
        if (!req_rdy || resp_val) begin
          $display("after reset req_rdy is %b and resp_val is %b, expected 1 and 0",
                   req_rdy, resp_val);
          n_err++;
        end
      end
      // request accepted
      if (req_val && req_rdy) begin
        expected = signed_product(req_msg);
        if (exp_known && (exp_product != expected)) begin
          $display("table product %h for %0d * %0d disagrees with the signed model %h",
                   exp_product, req_msg.a, req_msg.b, expected);
          n_err++;
        end
        sent_q.push_back(req_msg);
        model_q.push_back(expected);
        if (model_q.size() > max_in_flight) begin
          max_in_flight = model_q.size();
        end
      end
      // a stalled response must stay put
      if (stalled && !resp_val) begin
        $display("resp_val dropped at %0t while the consumer was stalled", $time);
        n_err++;
      end else if (stalled && (resp_msg != held_msg)) begin
        $display("[ERROR] %0t: resp_msg changed while stalled, expected %h, actual %h",
                 $time, held_msg, resp_msg);
        n_err++;
      end
      // response taken
      if (resp_val && resp_rdy) begin
        n_resp++;
        if (model_q.size() == 0) begin
          $display("response %0d at %0t arrived with no request outstanding", n_resp, $time);
          n_err++;
        end else begin
          sent     = sent_q.pop_front();
          expected = model_q.pop_front();
          if (resp_msg.result !== expected) begin
            $display("[ERROR] %0t: resp_msg expected %h, actual %h (test %0d, %0d * %0d)",
                     $time, expected, resp_msg.result, n_resp, sent.a, sent.b);
            n_err++;
          end else begin
            $display("test %0d: %0d * %0d = %0d ok", n_resp, sent.a, sent.b,
                     resp_msg.result);
          end
        end
      end
      stalled  = resp_val && !resp_rdy;
      held_msg = resp_msg;
    end
    resp_count    <= n_resp;
    error_count   <= n_err;
    pending_count <= model_q.size();
    peak_pending  <= max_in_flight;
  end

endmodule

// File: verilog/imul_unit.sv
// imul unit top level
// request queue -> iterative multiplier -> response queue

module imul_unit
  import imul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  input  mul_req_t  req_msg,
  input  logic      req_val,
  output logic      req_rdy,

  output mul_resp_t resp_msg,
  output logic      resp_val,
  input  logic      resp_rdy
);

  // request queue to multiplier
  mul_req_t  q_req_msg;
  logic      q_req_val;
  logic      q_req_rdy;
  // multiplier to response queue
  mul_resp_t m_resp_msg;
  logic      m_resp_val;
  logic      m_resp_rdy;
  // control/datapath
  logic      load;
  logic      step;
  logic      add_en;
  logic      count_zero;
  logic      b_lsb;

  // ----------------------------------------
  // request buffering
  // ----------------------------------------

  imul_msg_queue #(.msg_t(mul_req_t)) req_queue_i (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (req_msg),
    .enq_val (req_val),
    .enq_rdy (req_rdy),
    .deq_msg (q_req_msg),
    .deq_val (q_req_val),
    .deq_rdy (q_req_rdy)
  );

  // sequencing
  imul_iter_ctrl ctrl_i (
    .clk        (clk),
    .reset      (reset),
    .req_val    (q_req_val),
    .req_rdy    (q_req_rdy),
    .resp_val   (m_resp_val),
    .resp_rdy   (m_resp_rdy),
    .count_zero (count_zero),
    .b_lsb      (b_lsb),
    .load       (load),
    .step       (step),
    .add_en     (add_en)
  );

  // shift-and-add
  imul_iter_dpath dpath_i (
    .clk        (clk),
    .reset      (reset),
    .req_msg    (q_req_msg),
    .load       (load),
    .step       (step),
    .add_en     (add_en),
    .count_zero (count_zero),
    .b_lsb      (b_lsb),
    .resp_msg   (m_resp_msg)
  );

  // ----------------------------------------
  // response buffering
  // ----------------------------------------

  // holds finished products while the consumer stalls
  imul_msg_queue #(.msg_t(mul_resp_t)) resp_queue_i (
    .clk     (clk),
    .reset   (reset),
    .enq_msg (m_resp_msg),
    .enq_val (m_resp_val),
    .enq_rdy (m_resp_rdy),
    .deq_msg (resp_msg),
    .deq_val (resp_val),
    .deq_rdy (resp_rdy)
  );

endmodule

// File: verilog/imul_iter_dpath.sv
// imul iterative datapath
// unsigned shift-and-add over the operand magnitudes, sign restored on output

module imul_iter_dpath
  import imul_pkg::*;
(
  input  logic      clk,
  input  logic      reset,

  // operands from the request queue
  input  mul_req_t  req_msg,

  // control
  input  logic      load,
  input  logic      step,
  input  logic      add_en,

  // status back to control
  output logic      count_zero,
  output logic      b_lsb,

  // product towards the response queue
  output mul_resp_t resp_msg
);

  logic [OPERAND_WIDTH-1:0] mag_a;
  logic [OPERAND_WIDTH-1:0] mag_b;
  logic [RESULT_WIDTH-1:0]  a_reg;
  logic [OPERAND_WIDTH-1:0] b_reg;
  logic [RESULT_WIDTH-1:0]  acc_reg;
  logic [COUNT_WIDTH-1:0]   count_reg;
  logic                     neg_reg;

  // ----------------------------------------
  // operand magnitudes
  // ----------------------------------------

  // most negative operand maps to 2^31, still fits unsigned
  assign mag_a = req_msg.a[OPERAND_WIDTH-1] ? unsigned'(-req_msg.a) : unsigned'(req_msg.a);
  assign mag_b = req_msg.b[OPERAND_WIDTH-1] ? unsigned'(-req_msg.b) : unsigned'(req_msg.b);

  // shift registers, accumulator and sign
  always_ff @(posedge clk) begin
    if (load) begin
      // multiplicand zero extended to full product width
      a_reg   <= {{(RESULT_WIDTH-OPERAND_WIDTH){1'b0}}, mag_a};
      b_reg   <= mag_b;
      acc_reg <= '0;
      // product negative when exactly one operand is
      neg_reg <= req_msg.a[OPERAND_WIDTH-1] ^ req_msg.b[OPERAND_WIDTH-1];
    end else if (step) begin
      if (add_en) begin
        acc_reg <= acc_reg + a_reg;
      end
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // iteration counter, 31 down to 0
  always_ff @(posedge clk) begin
    if (reset) begin
      count_reg <= '0;
    end else if (load) begin
      count_reg <= COUNT_WIDTH'(OPERAND_WIDTH - 1);
    end else if (step) begin
      count_reg <= count_reg - 1'b1;
    end
  end

  // ----------------------------------------
  // status and result
  // ----------------------------------------

  assign count_zero = (count_reg == '0);
  // multiplier bit for the current iteration
  assign b_lsb = b_reg[0];

  // two's complement of the magnitude product when negative
  assign resp_msg.result = neg_reg ? (~acc_reg + 1'b1) : acc_reg;

endmodule

// File: verilog/imul_iter_ctrl.sv
// imul iterative control
// idle/calculate/done FSM sequencing the shift-and-add datapath

module imul_iter_ctrl
  import imul_pkg::*;
(
  input  logic clk,
  input  logic reset,

  // request side handshake
  input  logic req_val,
  output logic req_rdy,

  // response side handshake
  output logic resp_val,
  input  logic resp_rdy,

  // datapath status
  input  logic count_zero,
  input  logic b_lsb,

  // datapath control
  output logic load,
  output logic step,
  output logic add_en
);

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  // ----------------------------------------
  // state register
  // ----------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= CTRL_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE: begin
        if (load) begin
          state_d = CTRL_CALC;
        end
      end
      CTRL_CALC: begin
        // last iteration runs while the counter reads zero
        if (count_zero) begin
          state_d = CTRL_DONE;
        end
      end
      CTRL_DONE: begin
        if (resp_val && resp_rdy) begin
          state_d = CTRL_IDLE;
        end
      end
      default: state_d = CTRL_IDLE;
    endcase
  end

  // ----------------------------------------
  // outputs
  // ----------------------------------------

  // both readies/valids depend on state alone
  assign req_rdy  = (state_q == CTRL_IDLE);
  assign resp_val = (state_q == CTRL_DONE);

  // capture operands on the accepting edge
  assign load = req_rdy && req_val;
  // one iteration per calculate cycle
  assign step = (state_q == CTRL_CALC);
  // add partial product when current multiplier bit is set
  assign add_en = step && b_lsb;

  // state never leaves the three legal codes
  state_legal_a: assert property (@(posedge clk) disable iff (reset)
    state_q inside {CTRL_IDLE, CTRL_CALC, CTRL_DONE});

  // an accepted request gets exactly 32 iterations, then the result is offered
  calc_length_a: assert property (@(posedge clk) disable iff (reset)
    load |=> step [*32] ##1 (resp_val && !step));

endmodule

// File: verilog/imul_msg_queue.sv
// imul message queue
// small circular FIFO with valid/ready on both sides, payload given as a type

module imul_msg_queue
  import imul_pkg::*;
#(
  parameter type msg_t = mul_req_t
) (
  input  logic clk,
  input  logic reset,

  input  msg_t enq_msg,
  input  logic enq_val,
  output logic enq_rdy,

  output msg_t deq_msg,
  output logic deq_val,
  input  logic deq_rdy
);

  msg_t                       entries [QUEUE_DEPTH];
  logic [QUEUE_PTR_WIDTH-1:0] wr_ptr;
  logic [QUEUE_PTR_WIDTH-1:0] rd_ptr;
  logic [QUEUE_CNT_WIDTH-1:0] count;
  logic                       do_enq;
  logic                       do_deq;

  // ----------------------------------------
  // handshakes
  // ----------------------------------------

  // ready only looks at occupancy, so a full queue refuses even on a read
  assign enq_rdy = (count != QUEUE_CNT_WIDTH'(QUEUE_DEPTH));
  assign deq_val = (count != '0);
  // head entry, visible the cycle after it was written
  assign deq_msg = entries[rd_ptr];

  assign do_enq = enq_val && enq_rdy;
  assign do_deq = deq_val && deq_rdy;

  // storage
  always_ff @(posedge clk) begin
    if (do_enq) begin
      entries[wr_ptr] <= enq_msg;
    end
  end

  // pointers wrap on their own since depth is a power of two
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_deq) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // occupancy only moves when one side fires alone
      case ({do_enq, do_deq})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ----------------------------------------
  // checks
  // ----------------------------------------

  // occupancy bounded by depth
  count_in_range_a: assert property (@(posedge clk) disable iff (reset)
    count <= QUEUE_CNT_WIDTH'(QUEUE_DEPTH));

  // head must not change while the consumer stalls
  deq_msg_stable_a: assert property (@(posedge clk) disable iff (reset)
    deq_val && !deq_rdy |=> $stable(deq_msg));

endmodule

// File: verilog/imul_pkg.sv
// imul shared definitions
// widths, queue sizing, control states and the request/response message types

package imul_pkg;

  // ----------------------------------------
  // datapath widths
  // ----------------------------------------

  // each operand is a two's complement word
  localparam int OPERAND_WIDTH = 32;
  // full signed product
  localparam int RESULT_WIDTH = 2 * OPERAND_WIDTH;
  // iteration counter, holds 31 down to 0
  localparam int COUNT_WIDTH = 5;

  // ----------------------------------------
  // queue sizing
  // ----------------------------------------

  // entries per queue, power of two
  localparam int QUEUE_DEPTH = 2;
  localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
  // one extra code so a full queue can be counted
  localparam int QUEUE_CNT_WIDTH = $clog2(QUEUE_DEPTH + 1);

  // iterative control states
  typedef enum logic [1:0] {
    CTRL_IDLE = 2'd0,
    CTRL_CALC = 2'd1,
    CTRL_DONE = 2'd2
  } ctrl_state_t;

  // request: two signed operands
  typedef struct packed {
    logic signed [OPERAND_WIDTH-1:0] a;
    logic signed [OPERAND_WIDTH-1:0] b;
  } mul_req_t;

  // response: full width signed product
  typedef struct packed {
    logic signed [RESULT_WIDTH-1:0] result;
  } mul_resp_t;

endpackage
